// ==== common/eeprom_pkg.sv ====
`include "eeprom_settings.svh"

package eeprom_pkg;

    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } eeprom_op_e;

    typedef struct packed {
        eeprom_op_e                op;
        logic [3:0]                dev_type;
        logic [`EEPROM_ADDR_W-1:0] addr;
        logic [7:0]                wdata;
    } eeprom_cmd_t;

    typedef struct packed {
        logic [7:0] rdata;
        logic       ack_error;
    } eeprom_rsp_t;

    // one-cycle pulses seen after the synchronizer
    typedef struct packed {
        logic start;
        logic stop;
        logic clk_rise;
        logic clk_fall;
        logic data_bit;
    } bus_event_t;

    typedef enum logic [2:0] {
        M_IDLE,
        M_START,
        M_SEND_BYTE,
        M_GET_ACK,
        M_RESTART,
        M_GET_BYTE,
        M_SEND_NACK,
        M_STOP
    } master_state_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_CTRL,
        S_ADDR,
        S_WDATA,
        S_RDATA,
        S_ACK,
        S_WAIT_ACK
    } slave_state_e;

endpackage

// ==== common/eeprom_settings.svh ====
`ifndef EEPROM_SETTINGS_SVH
`define EEPROM_SETTINGS_SVH

// system clocks per quarter of a serial bit
`define EEPROM_SCL_DIV 4

// byte address of three block bits plus the word address
`define EEPROM_ADDR_W 11

`define EEPROM_DEPTH 2048

// device-type nibble expected in the control byte
`define EEPROM_DEVICE_CODE 4'b1010

`endif

// ==== eeprom_slave/bus_condition_detector.sv ====
`timescale 1ns/1ps

module bus_condition_detector (
    input  logic                   sda,
    input  logic                   rst,
    input  logic                   serial_clk,
    input  logic                   serial_data,
    output eeprom_pkg::bus_event_t events
);
    // bit 1 is the synchronized value, bit 2 the one before it
    logic [2:0] clk_pipe;
    logic [2:0] data_pipe;
    logic       clk_high;

    always_ff @(posedge sda)
    begin
        if (rst)
        begin
            clk_pipe  <= 3'b111;
            data_pipe <= 3'b111;
        end
        else
        begin
            clk_pipe  <= {clk_pipe[1:0], serial_clk};
            data_pipe <= {data_pipe[1:0], serial_data};
        end
    end

    assign clk_high = clk_pipe[1] & clk_pipe[2];

    assign events.start    = clk_high & data_pipe[2] & ~data_pipe[1];
    assign events.stop     = clk_high & ~data_pipe[2] & data_pipe[1];
    assign events.clk_rise = clk_pipe[1] & ~clk_pipe[2];
    assign events.clk_fall = ~clk_pipe[1] & clk_pipe[2];
    assign events.data_bit = data_pipe[1];

endmodule

// ==== eeprom_slave/eeprom_array.sv ====
`timescale 1ns/1ps
`include "eeprom_settings.svh"

module eeprom_array (
    input  logic                      sda,
    input  logic                      wr_en,
    input  logic                      rd_en,
    input  logic [`EEPROM_ADDR_W-1:0] addr,
    input  logic [7:0]                wdata,
    output logic [7:0]                rdata
);
    logic [7:0] mem [0:`EEPROM_DEPTH-1];

    always_ff @(posedge sda)
    begin
        if (wr_en)
            mem[addr] <= wdata;
        if (rd_en)
            rdata <= mem[addr];
    end

endmodule

// ==== eeprom_slave/eeprom_slave.sv ====
`timescale 1ns/1ps
`include "eeprom_settings.svh"

module eeprom_slave (
    input  logic sda,
    input  logic rst,
    input  logic serial_clk,
    input  logic serial_data,
    input  logic write_protect,
    output logic data_low
);
    eeprom_pkg::bus_event_t    ev;
    eeprom_pkg::slave_state_e  state;
    eeprom_pkg::slave_state_e  after_ack;
    logic [1:0]                fall_dly;
    logic [2:0]                bit_cnt;
    logic [7:0]                shreg;
    logic [7:0]                rx_byte;
    logic [`EEPROM_ADDR_W-1:0] cur_addr;
    logic [7:0]                arr_wdata;
    logic [7:0]                arr_rdata;
    logic                      wr_en;
    logic                      rd_en;

    bus_condition_detector u_detect (
        .sda         (sda),
        .rst         (rst),
        .serial_clk  (serial_clk),
        .serial_data (serial_data),
        .events      (ev)
    );

    eeprom_array u_array (
        .sda   (sda),
        .wr_en (wr_en),
        .rd_en (rd_en),
        .addr  (cur_addr),
        .wdata (arr_wdata),
        .rdata (arr_rdata)
    );

    assign rx_byte = {shreg[6:0], ev.data_bit};

    always_ff @(posedge sda)
    begin
        if (rst)
        begin
            state    <= eeprom_pkg::S_IDLE;
            data_low <= 1'b0;
            fall_dly <= 2'b00;
            bit_cnt  <= 3'd0;
            wr_en    <= 1'b0;
            rd_en    <= 1'b0;
        end
        else
        begin
            // output changes two cycles after a seen clock fall
            fall_dly <= {fall_dly[0], ev.clk_fall};
            wr_en    <= 1'b0;
            rd_en    <= 1'b0;
            if (ev.start)
            begin
                state    <= eeprom_pkg::S_CTRL;
                bit_cnt  <= 3'd0;
                data_low <= 1'b0;
            end
            else if (ev.stop)
            begin
                state    <= eeprom_pkg::S_IDLE;
                data_low <= 1'b0;
            end
            else
            begin
                case (state)
                    eeprom_pkg::S_CTRL, eeprom_pkg::S_ADDR, eeprom_pkg::S_WDATA:
                    begin
                        if (ev.clk_rise)
                        begin
                            shreg   <= rx_byte;
                            bit_cnt <= bit_cnt + 3'd1;
                        end
                        if (ev.clk_rise && bit_cnt == 3'd7)
                        begin
                            state <= eeprom_pkg::S_ACK;
                            case (state)
                                eeprom_pkg::S_CTRL:
                                begin
                                    // wrong device type stays silent, which reads as NACK
                                    if (rx_byte[7:4] != `EEPROM_DEVICE_CODE)
                                        state <= eeprom_pkg::S_IDLE;
                                    else if (rx_byte[0])
                                    begin
                                        after_ack <= eeprom_pkg::S_RDATA;
                                        rd_en     <= 1'b1;
                                    end
                                    else
                                    begin
                                        after_ack <= eeprom_pkg::S_ADDR;
                                        cur_addr[`EEPROM_ADDR_W-1:8] <= rx_byte[3:1];
                                    end
                                end
                                eeprom_pkg::S_ADDR:
                                begin
                                    after_ack     <= eeprom_pkg::S_WDATA;
                                    cur_addr[7:0] <= rx_byte;
                                end
                                default:
                                begin
                                    after_ack <= eeprom_pkg::S_IDLE;
                                    arr_wdata <= rx_byte;
                                    wr_en     <= ~write_protect;
                                    if (write_protect)
                                        state <= eeprom_pkg::S_IDLE;
                                end
                            endcase
                        end
                    end
                    eeprom_pkg::S_ACK:
                    begin
                        // first fall pulls the ack low, the second ends it
                        if (fall_dly[1] && !data_low)
                            data_low <= 1'b1;
                        else if (fall_dly[1])
                        begin
                            state    <= after_ack;
                            shreg    <= arr_rdata;
                            data_low <= (after_ack == eeprom_pkg::S_RDATA) && !arr_rdata[7];
                        end
                    end
                    eeprom_pkg::S_RDATA:
                    begin
                        if (fall_dly[1])
                        begin
                            bit_cnt  <= bit_cnt + 3'd1;
                            shreg    <= {shreg[6:0], 1'b0};
                            data_low <= (bit_cnt != 3'd7) && !shreg[6];
                            if (bit_cnt == 3'd7)
                                state <= eeprom_pkg::S_WAIT_ACK;
                        end
                    end
                    eeprom_pkg::S_WAIT_ACK:
                    begin
                        // no sequential reads, so the master's bit ends the read
                        if (ev.clk_rise)
                            state <= eeprom_pkg::S_IDLE;
                    end
                    default:
                        data_low <= 1'b0;
                endcase
            end
        end
    end

endmodule

// ==== files.f ====
+incdir+common
common/eeprom_pkg.sv
eeprom_slave/bus_condition_detector.sv
eeprom_slave/eeprom_array.sv
eeprom_slave/eeprom_slave.sv
i2c_master/i2c_master.sv
verilog/eeprom_subsystem.sv
testbench/eeprom_tb.sv

// ==== i2c_master/i2c_master.sv ====
`timescale 1ns/1ps
`include "eeprom_settings.svh"

module i2c_master (
    input  logic                    sda,
    input  logic                    rst,
    input  logic                    cmd_valid,
    input  eeprom_pkg::eeprom_cmd_t cmd,
    output logic                    busy,
    output logic                    done,
    output eeprom_pkg::eeprom_rsp_t rsp,
    output logic                    clk_low,
    output logic                    data_low,
    input  logic                    data_in
);
    localparam int DIV_W = $clog2(`EEPROM_SCL_DIV + 1);

    eeprom_pkg::master_state_e state;
    eeprom_pkg::eeprom_cmd_t   cmd_q;
    logic [DIV_W-1:0] div_cnt;
    logic [1:0]       q;
    logic [2:0]       bit_cnt;
    logic [1:0]       phase;
    logic [7:0]       shreg;
    logic [7:0]       rx_byte;
    logic [6:0]       ctrl_base;
    logic             ack_err;
    logic             tick;
    logic             bit_clk_low;
    logic             clk_low_nxt;
    logic             data_low_nxt;

    assign tick        = (div_cnt == DIV_W'(`EEPROM_SCL_DIV - 1));
    assign ctrl_base   = {cmd_q.dev_type, cmd_q.addr[`EEPROM_ADDR_W-1:8]};
    // clock high in the middle two quarters of a bit
    assign bit_clk_low = (q == 2'd0) || (q == 2'd3);

    always_comb
    begin
        clk_low_nxt  = 1'b0;
        data_low_nxt = 1'b0;
        case (state)
            eeprom_pkg::M_START, eeprom_pkg::M_RESTART:
            begin
                clk_low_nxt  = bit_clk_low;
                data_low_nxt = q[1];
            end
            eeprom_pkg::M_SEND_BYTE:
            begin
                clk_low_nxt  = bit_clk_low;
                data_low_nxt = ~shreg[7];
            end
            eeprom_pkg::M_GET_ACK, eeprom_pkg::M_GET_BYTE, eeprom_pkg::M_SEND_NACK:
                clk_low_nxt = bit_clk_low;
            eeprom_pkg::M_STOP:
            begin
                // data rises while the clock is high
                clk_low_nxt  = (q == 2'd0);
                data_low_nxt = ~q[1];
            end
            default:
                clk_low_nxt = 1'b0;
        endcase
    end

    always_ff @(posedge sda)
    begin
        if (rst)
        begin
            state    <= eeprom_pkg::M_IDLE;
            busy     <= 1'b0;
            done     <= 1'b0;
            clk_low  <= 1'b0;
            data_low <= 1'b0;
            div_cnt  <= '0;
            q        <= 2'd0;
        end
        else
        begin
            done     <= 1'b0;
            clk_low  <= clk_low_nxt;
            data_low <= data_low_nxt;
            if (state == eeprom_pkg::M_IDLE)
            begin
                div_cnt <= '0;
                q       <= 2'd0;
                if (cmd_valid)
                begin
                    cmd_q   <= cmd;
                    rx_byte <= 8'h00;
                    ack_err <= 1'b0;
                    phase   <= 2'd0;
                    bit_cnt <= 3'd0;
                    busy    <= 1'b1;
                    state   <= eeprom_pkg::M_START;
                end
            end
            else if (!tick)
                div_cnt <= div_cnt + 1'b1;
            else
            begin
                div_cnt <= '0;
                q       <= q + 2'd1;
                // sample in the third quarter
                if (q == 2'd2 && state == eeprom_pkg::M_GET_ACK && data_in)
                    ack_err <= 1'b1;
                if (q == 2'd2 && state == eeprom_pkg::M_GET_BYTE)
                    rx_byte <= {rx_byte[6:0], data_in};
                if (q == 2'd3)
                begin
                    case (state)
                        eeprom_pkg::M_START:
                        begin
                            shreg <= {ctrl_base, 1'b0};
                            state <= eeprom_pkg::M_SEND_BYTE;
                        end
                        eeprom_pkg::M_RESTART:
                        begin
                            shreg <= {ctrl_base, 1'b1};
                            state <= eeprom_pkg::M_SEND_BYTE;
                        end
                        eeprom_pkg::M_SEND_BYTE:
                        begin
                            shreg   <= {shreg[6:0], 1'b0};
                            bit_cnt <= bit_cnt + 3'd1;
                            if (bit_cnt == 3'd7)
                                state <= eeprom_pkg::M_GET_ACK;
                        end
                        eeprom_pkg::M_GET_ACK:
                        begin
                            phase <= phase + 2'd1;
                            if (ack_err)
                                state <= eeprom_pkg::M_STOP;
                            else if (phase == 2'd0)
                            begin
                                shreg <= cmd_q.addr[7:0];
                                state <= eeprom_pkg::M_SEND_BYTE;
                            end
                            else if (phase == 2'd1 && cmd_q.op == eeprom_pkg::OP_READ)
                                state <= eeprom_pkg::M_RESTART;
                            else if (phase == 2'd1)
                            begin
                                shreg <= cmd_q.wdata;
                                state <= eeprom_pkg::M_SEND_BYTE;
                            end
                            else if (cmd_q.op == eeprom_pkg::OP_READ)
                                state <= eeprom_pkg::M_GET_BYTE;
                            else
                                state <= eeprom_pkg::M_STOP;
                        end
                        eeprom_pkg::M_GET_BYTE:
                        begin
                            bit_cnt <= bit_cnt + 3'd1;
                            if (bit_cnt == 3'd7)
                                state <= eeprom_pkg::M_SEND_NACK;
                        end
                        eeprom_pkg::M_SEND_NACK:
                            state <= eeprom_pkg::M_STOP;
                        default:
                        begin
                            state         <= eeprom_pkg::M_IDLE;
                            busy          <= 1'b0;
                            done          <= 1'b1;
                            rsp.rdata     <= ack_err ? 8'h00 : rx_byte;
                            rsp.ack_error <= ack_err;
                        end
                    endcase
                end
            end
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module eeprom_tb -f files.f -o eeprom_sim

sim_output=$(./obj_dir/eeprom_sim 2>&1) || true
echo "$sim_output"

if echo "$sim_output" | grep -q "SIMULATION PASSED"; then
    exit 0
else
    exit 1
fi

// ==== testbench/eeprom_tb.sv ====
`timescale 1ns/1ps
`include "eeprom_settings.svh"

module eeprom_tb;
    // up to 40 commands of at most 40 bits each, doubled for margin
    localparam int TIMEOUT_CYCLES = 40 * 40 * 4 * `EEPROM_SCL_DIV * 2;
    localparam int BIT_CYCLES     = 4 * `EEPROM_SCL_DIV;
    localparam logic [3:0] WRONG_CODE = 4'b0110;

    logic                    sda;
    logic                    rst;
    logic                    cmd_valid;
    eeprom_pkg::eeprom_cmd_t cmd;
    logic                    write_protect;
    logic                    busy;
    logic                    done;
    eeprom_pkg::eeprom_rsp_t rsp;

    logic [7:0] ref_mem [0:`EEPROM_DEPTH-1];
    int         cycle_count;

    eeprom_subsystem DUT (
        .sda           (sda),
        .rst           (rst),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .write_protect (write_protect),
        .busy          (busy),
        .done          (done),
        .rsp           (rsp)
    );

    initial
    begin
        sda = 1'b0;
        forever #4 sda = ~sda;
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge sda);
            cycle_count++;
        end
        $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SIMULATION FAILED");
        $fatal(1, "run aborted by the cycle limit");
    end

    task automatic next_cycle();
        @(posedge sda);
        #1;
    endtask

    task automatic check_rsp(input string name, input eeprom_pkg::eeprom_rsp_t exp,
                             input eeprom_pkg::eeprom_rsp_t act);
        if (act !== exp)
        begin
            $display("[FAIL] %s: expected rdata=%h ack_error=%b, actual rdata=%h ack_error=%b",
                     name, exp.rdata, exp.ack_error, act.rdata, act.ack_error);
            $display("SIMULATION FAILED");
            $fatal(1, "stopping at the first error");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
            $display("SIMULATION FAILED");
            $fatal(1, "stopping at the first error");
        end
    endtask

    function automatic eeprom_pkg::eeprom_cmd_t make_cmd(input eeprom_pkg::eeprom_op_e op,
                                                         input logic [3:0] dev,
                                                         input logic [`EEPROM_ADDR_W-1:0] addr,
                                                         input logic [7:0] wdata);
        eeprom_pkg::eeprom_cmd_t c;
        c.op       = op;
        c.dev_type = dev;
        c.addr     = addr;
        c.wdata    = wdata;
        return c;
    endfunction

    // one strobe, then wait for done; the watchdog bounds the wait
    task automatic run_cmd(input string name, input eeprom_pkg::eeprom_cmd_t c,
                           output eeprom_pkg::eeprom_rsp_t r);
        cmd       = c;
        cmd_valid = 1'b1;
        next_cycle();
        cmd_valid = 1'b0;
        check_flag({name, " busy after strobe"}, 1'b1, busy);
        while (!done)
            next_cycle();
        check_flag({name, " busy at done"}, 1'b0, busy);
        r = rsp;
    endtask

    task automatic write_tracked(input string name, input logic [`EEPROM_ADDR_W-1:0] addr,
                                 input logic [7:0] data);
        eeprom_pkg::eeprom_rsp_t r;
        run_cmd(name, make_cmd(eeprom_pkg::OP_WRITE, `EEPROM_DEVICE_CODE, addr, data), r);
        check_flag({name, " ack_error"}, 1'b0, r.ack_error);
        ref_mem[addr] = data;
    endtask

    task automatic read_compare(input string name, input logic [`EEPROM_ADDR_W-1:0] addr);
        eeprom_pkg::eeprom_rsp_t r;
        eeprom_pkg::eeprom_rsp_t exp;
        exp.rdata     = ref_mem[addr];
        exp.ack_error = 1'b0;
        run_cmd(name, make_cmd(eeprom_pkg::OP_READ, `EEPROM_DEVICE_CODE, addr, 8'h00), r);
        check_rsp(name, exp, r);
    endtask

    task automatic test_basic_write_read();
        check_flag("reset busy", 1'b0, busy);
        check_flag("reset done", 1'b0, done);
        write_tracked("basic write", 11'h123, 8'h5C);
        read_compare("basic read", 11'h123);
    endtask

    task automatic test_block_bits();
        // same word address in two blocks
        write_tracked("block 0 write", 11'h0A5, 8'h3A);
        write_tracked("block 7 write", 11'h7A5, 8'hC4);
        read_compare("block 0 read", 11'h0A5);
        read_compare("block 7 read", 11'h7A5);
    endtask

    task automatic test_write_protect();
        eeprom_pkg::eeprom_rsp_t r;
        eeprom_pkg::eeprom_rsp_t exp;
        exp.rdata     = 8'h00;
        exp.ack_error = 1'b1;
        write_tracked("protect setup write", 11'h2F0, 8'h96);
        write_protect = 1'b1;
        run_cmd("protected write",
                make_cmd(eeprom_pkg::OP_WRITE, `EEPROM_DEVICE_CODE, 11'h2F0, 8'h69), r);
        check_rsp("protected write", exp, r);
        write_protect = 1'b0;
        read_compare("read after protected write", 11'h2F0);
    endtask

    task automatic test_wrong_device();
        eeprom_pkg::eeprom_rsp_t r;
        eeprom_pkg::eeprom_rsp_t exp;
        exp.rdata     = 8'h00;
        exp.ack_error = 1'b1;
        run_cmd("wrong device write",
                make_cmd(eeprom_pkg::OP_WRITE, WRONG_CODE, 11'h123, 8'hFF), r);
        check_rsp("wrong device write", exp, r);
        run_cmd("wrong device read",
                make_cmd(eeprom_pkg::OP_READ, WRONG_CODE, 11'h123, 8'h00), r);
        check_rsp("wrong device read", exp, r);
        read_compare("read after wrong device", 11'h123);
    endtask

    task automatic test_random_block();
        logic [`EEPROM_ADDR_W-1:0] addrs [0:7];
        logic [`EEPROM_ADDR_W-1:0] tmp;
        logic [31:0]               r;
        logic                      fresh;
        int                        j;
        for (int i = 0; i < 8; i++)
        begin
            fresh = 1'b0;
            while (!fresh)
            begin
                r        = $urandom;
                addrs[i] = r[`EEPROM_ADDR_W-1:0];
                fresh    = 1'b1;
                for (int k = 0; k < i; k++)
                    if (addrs[k] == addrs[i])
                        fresh = 1'b0;
            end
            r = $urandom;
            write_tracked("random write", addrs[i], r[7:0]);
        end
        // shuffle the read order
        for (int i = 7; i > 0; i--)
        begin
            j        = int'($urandom % (i + 1));
            tmp      = addrs[i];
            addrs[i] = addrs[j];
            addrs[j] = tmp;
        end
        for (int i = 0; i < 8; i++)
            read_compare("random read", addrs[i]);
    endtask

    task automatic test_dropped_command();
        int done_count;
        cmd       = make_cmd(eeprom_pkg::OP_WRITE, `EEPROM_DEVICE_CODE, 11'h3C2, 8'hE1);
        cmd_valid = 1'b1;
        next_cycle();
        // second strobe lands while the first transaction runs
        cmd = make_cmd(eeprom_pkg::OP_WRITE, `EEPROM_DEVICE_CODE, 11'h3C2, 8'h1E);
        check_flag("dropped busy during second strobe", 1'b1, busy);
        next_cycle();
        cmd_valid = 1'b0;
        while (!done)
            next_cycle();
        check_flag("dropped first ack_error", 1'b0, rsp.ack_error);
        done_count = 1;
        for (int n = 0; n < 40 * BIT_CYCLES; n++)
        begin
            next_cycle();
            if (done)
                done_count++;
        end
        check_flag("dropped single done", 1'b1, done_count == 1);
        ref_mem[11'h3C2] = 8'hE1;
        read_compare("dropped read", 11'h3C2);
    endtask

    initial
    begin
        void'($urandom(10225));
        rst           = 1'b1;
        cmd_valid     = 1'b0;
        cmd           = '0;
        write_protect = 1'b0;
        repeat (10) @(posedge sda);
        #1;
        rst = 1'b0;
        next_cycle();

        test_basic_write_read();
        test_block_bits();
        test_write_protect();
        test_wrong_device();
        test_random_block();
        test_dropped_command();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== verilog/eeprom_subsystem.sv ====
`timescale 1ns/1ps

module eeprom_subsystem (
    input  logic                    sda,
    input  logic                    rst,
    input  logic                    cmd_valid,
    input  eeprom_pkg::eeprom_cmd_t cmd,
    input  logic                    write_protect,
    output logic                    busy,
    output logic                    done,
    output eeprom_pkg::eeprom_rsp_t rsp
);
    logic master_clk_low;
    logic master_data_low;
    logic slave_data_low;
    logic serial_clk;
    logic serial_data;

    // open-drain pair where a line is high unless someone pulls it low
    assign serial_clk  = ~master_clk_low;
    assign serial_data = ~(master_data_low | slave_data_low);

    i2c_master u_master (
        .sda       (sda),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .busy      (busy),
        .done      (done),
        .rsp       (rsp),
        .clk_low   (master_clk_low),
        .data_low  (master_data_low),
        .data_in   (serial_data)
    );

    eeprom_slave u_slave (
        .sda           (sda),
        .rst           (rst),
        .serial_clk    (serial_clk),
        .serial_data   (serial_data),
        .write_protect (write_protect),
        .data_low      (slave_data_low)
    );

endmodule
